// ==== common/switch_pkg.sv ====
/*
 * Switch datapath package
 * Stream widths, sideband field positions, port codes
 * and the beat struct shared by the FIFOs and both blocks
 */
`default_nettype none

package switch_pkg;

   //////////////////////////////
   // Stream widths
   //////////////////////////////
   localparam int axis_data_width = 64;
   localparam int axis_strb_width = axis_data_width / 8;
   localparam int user_width      = 128;

   // Sideband fields, 8 bits each
   // Bits 0..15 carry the packet length in bytes
   localparam int src_port_pos = 16;
   localparam int dst_port_pos = 24;

   //////////////////////////////
   // Ports and FIFO sizes
   //////////////////////////////
   localparam int num_ports = 4;

   // Arbiter queues, 8 entries each
   localparam int in_fifo_depth_bits  = 3;
   // Lookup output queue, 4 entries
   localparam int opl_fifo_depth_bits = 2;

   // One-hot port code, MAC on even bits and CPU on odd bits
   typedef logic [7:0] port_onehot_t;

   // One stream beat, 201 bits
   typedef struct packed {
      logic                       last;
      logic [user_width-1:0]      user;
      logic [axis_strb_width-1:0] strb;
      logic [axis_data_width-1:0] data;
   } axis_beat_t;

endpackage

`default_nettype wire

// ==== common/axis_if.sv ====
/*
 * AXI stream interface
 * Data, byte strobes, sideband word and tlast with a
 * valid/ready handshake
 */
`timescale 1ns/1ps
`default_nettype none

interface axis_if;
   import switch_pkg::*;

   logic [axis_data_width-1:0] tdata;
   logic [axis_strb_width-1:0] tstrb;
   logic [user_width-1:0]      tuser;
   logic                       tvalid;
   logic                       tready;
   // Final beat of a packet
   logic                       tlast;

   // Source side
   modport master (
      output tdata, tstrb, tuser, tvalid, tlast,
      input  tready
   );

   // Sink side
   modport slave (
      input  tdata, tstrb, tuser, tvalid, tlast,
      output tready
   );

   // Passive observer
   modport monitor (
      input tdata, tstrb, tuser, tvalid, tready, tlast
   );

endinterface

`default_nettype wire

// ==== verilog/small_fifo.sv ====
/*
 * Small synchronous FIFO of stream beats
 * First-word fall-through, head always on dout
 * nearly_full is set with one free entry left
 */
`timescale 1ns/1ps
`default_nettype none

module small_fifo #(
   parameter int depth_bits = 2
) (
   input  logic                   clk,
   input  logic                   axi_resetn,
   input  switch_pkg::axis_beat_t din,
   input  logic                   wr_en,
   input  logic                   rd_en,
   output switch_pkg::axis_beat_t dout,
   output logic                   empty,
   output logic                   nearly_full
);
   import switch_pkg::*;

   // Beat storage
   axis_beat_t mem [2**depth_bits];

   logic [depth_bits-1:0] wr_ptr;
   logic [depth_bits-1:0] rd_ptr;
   // One extra bit so a full buffer is distinct from empty
   logic [depth_bits:0]   count;
   logic                  full;
   logic                  do_wr;
   logic                  do_rd;

   assign full        = (count == (depth_bits + 1)'(2**depth_bits));
   assign empty       = (count == '0);
   assign nearly_full = (count >= (depth_bits + 1)'(2**depth_bits - 1));

   // Drop writes when full and reads when empty
   assign do_wr = wr_en && !full;
   assign do_rd = rd_en && !empty;

   assign dout = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= din;
      end
   end

   // Pointers and occupancy
   always_ff @(posedge clk) begin
      if (axi_resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + depth_bits'(1);
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + depth_bits'(1);
         end
         // Simultaneous push and pop keep the count
         case ({do_wr, do_rd})
            2'b10:   count <= count + (depth_bits + 1)'(1);
            2'b01:   count <= count - (depth_bits + 1)'(1);
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== input_arbiter/input_arbiter.sv ====
/*
 * Input arbiter
 * Queues four receive streams and grants whole packets
 * round-robin onto one output stream, stamping the
 * source port code into the sideband word
 */
`timescale 1ns/1ps
`default_nettype none

module input_arbiter (
   input logic clk,
   input logic axi_resetn,
   axis_if.slave  s [0:switch_pkg::num_ports-1],
   axis_if.master m
);
   import switch_pkg::*;

   typedef logic [$clog2(num_ports)-1:0] port_idx_t;

   //////////////////////////////
   // Input queues
   //////////////////////////////
   axis_beat_t               fifo_din  [num_ports];
   axis_beat_t               fifo_dout [num_ports];
   logic [num_ports-1:0]     fifo_wr_en;
   logic [num_ports-1:0]     fifo_rd_en;
   logic [num_ports-1:0]     fifo_empty;
   logic [num_ports-1:0]     fifo_nearly_full;

   genvar i;
   generate
      for (i = 0; i < num_ports; i++) begin : g_in
         // Pack the incoming beat
         assign fifo_din[i] = '{last: s[i].tlast,
                                user: s[i].tuser,
                                strb: s[i].tstrb,
                                data: s[i].tdata};

         // Keep one entry spare for the beat in flight
         assign s[i].tready   = !fifo_nearly_full[i];
         assign fifo_wr_en[i] = s[i].tvalid && !fifo_nearly_full[i];

         small_fifo #(
            .depth_bits (in_fifo_depth_bits)
         ) u_in_fifo (
            .clk         (clk),
            .axi_resetn  (axi_resetn),
            .din         (fifo_din[i]),
            .wr_en       (fifo_wr_en[i]),
            .rd_en       (fifo_rd_en[i]),
            .dout        (fifo_dout[i]),
            .empty       (fifo_empty[i]),
            .nearly_full (fifo_nearly_full[i])
         );
      end
   endgenerate

   //////////////////////////////
   // Round-robin grant
   //////////////////////////////
   // Input to serve next or the one locked on
   port_idx_t  grant;
   // Set while a packet is in progress or shown on m
   logic       locked;
   port_idx_t  pick;
   port_idx_t  cand;
   port_idx_t  sel;
   logic       out_valid;
   logic       out_xfer;
   axis_beat_t out_beat;

   // First non-empty queue at or after the grant pointer
   // Wrap relies on num_ports being a power of two
   always_comb begin
      pick = grant;
      cand = grant;
      for (int off = num_ports - 1; off >= 0; off--) begin
         cand = grant + port_idx_t'(off);
         if (!fifo_empty[cand]) begin
            pick = cand;
         end
      end
   end

   // Hold the choice once it is offered so the payload stays stable
   assign sel       = locked ? grant : pick;
   assign out_valid = !fifo_empty[sel];
   assign out_xfer  = out_valid && m.tready;

   always_ff @(posedge clk) begin
      if (axi_resetn) begin
         grant  <= '0;
         locked <= 1'b0;
      end else if (out_xfer && out_beat.last) begin
         // Move past this input once the packet is done
         grant  <= sel + port_idx_t'(1);
         locked <= 1'b0;
      end else if (out_valid) begin
         grant  <= sel;
         locked <= 1'b1;
      end
   end

   generate
      for (i = 0; i < num_ports; i++) begin : g_rd
         assign fifo_rd_en[i] = out_xfer && (sel == port_idx_t'(i));
      end
   endgenerate

   //////////////////////////////
   // Output and source stamp
   //////////////////////////////
   always_comb begin
      out_beat = fifo_dout[sel];
      // Overwrite whatever the upstream put in the source field
      out_beat.user[src_port_pos +: 8] = port_onehot_t'(1) << sel;
   end

   assign m.tdata  = out_beat.data;
   assign m.tstrb  = out_beat.strb;
   assign m.tuser  = out_beat.user;
   assign m.tlast  = out_beat.last;
   assign m.tvalid = out_valid;

endmodule

`default_nettype wire

// ==== output_port_lookup/output_port_lookup.sv ====
/*
 * Output port lookup
 * Rewrites the destination field on the first beat of each
 * packet, MAC ports to the CPU port above and CPU ports
 * to the MAC port below
 */
`timescale 1ns/1ps
`default_nettype none

module output_port_lookup (
   input logic clk,
   input logic axi_resetn,
   axis_if.slave  s,
   axis_if.master m
);
   import switch_pkg::*;

   typedef enum logic {
      st_header,
      st_in_packet
   } state_t;

   state_t       state;
   logic         in_accept;
   port_onehot_t src_port;
   port_onehot_t dst_port;
   logic         from_cpu;
   axis_beat_t   fifo_din;
   axis_beat_t   fifo_dout;
   logic         fifo_empty;
   logic         fifo_nearly_full;
   logic         fifo_rd_en;

   assign in_accept = s.tvalid && s.tready;

   //////////////////////////////
   // First-beat tracking
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (axi_resetn) begin
         state <= st_header;
      end else if (in_accept) begin
         // Back to header after the last beat
         state <= s.tlast ? st_header : st_in_packet;
      end
   end

   //////////////////////////////
   // Destination rewrite
   //////////////////////////////
   assign src_port = s.tuser[src_port_pos +: 8];

   // CPU ports sit on the odd bits
   assign from_cpu = |(src_port & 8'haa);

   // CPU goes down one bit to its MAC, MAC goes up one
   assign dst_port = from_cpu ? (src_port >> 1) : (src_port << 1);

   always_comb begin
      fifo_din = '{last: s.tlast, user: s.tuser, strb: s.tstrb, data: s.tdata};
      // Only the header beat is touched
      if (state == st_header) begin
         fifo_din.user[dst_port_pos +: 8] = dst_port;
      end
   end

   //////////////////////////////
   // Output queue
   //////////////////////////////
   assign s.tready = !fifo_nearly_full;

   small_fifo #(
      .depth_bits (opl_fifo_depth_bits)
   ) u_out_fifo (
      .clk         (clk),
      .axi_resetn  (axi_resetn),
      .din         (fifo_din),
      .wr_en       (in_accept),
      .rd_en       (fifo_rd_en),
      .dout        (fifo_dout),
      .empty       (fifo_empty),
      .nearly_full (fifo_nearly_full)
   );

   // Pop on each transfer
   assign fifo_rd_en = !fifo_empty && m.tready;

   assign m.tvalid = !fifo_empty;
   assign m.tdata  = fifo_dout.data;
   assign m.tstrb  = fifo_dout.strb;
   assign m.tuser  = fifo_dout.user;
   assign m.tlast  = fifo_dout.last;

endmodule

`default_nettype wire

// ==== verilog/datapath_top.sv ====
/*
 * Switch datapath top level
 * Four receive streams through the input arbiter and the
 * output port lookup onto one output stream
 */
`timescale 1ns/1ps
`default_nettype none

module datapath_top (
   input  logic                                   clk,
   input  logic                                   axi_resetn,

   // MAC0
   input  logic [switch_pkg::axis_data_width-1:0] s0_tdata,
   input  logic [switch_pkg::axis_strb_width-1:0] s0_tstrb,
   input  logic [switch_pkg::user_width-1:0]      s0_tuser,
   input  logic                                   s0_tvalid,
   output logic                                   s0_tready,
   input  logic                                   s0_tlast,

   // CPU0
   input  logic [switch_pkg::axis_data_width-1:0] s1_tdata,
   input  logic [switch_pkg::axis_strb_width-1:0] s1_tstrb,
   input  logic [switch_pkg::user_width-1:0]      s1_tuser,
   input  logic                                   s1_tvalid,
   output logic                                   s1_tready,
   input  logic                                   s1_tlast,

   // MAC1
   input  logic [switch_pkg::axis_data_width-1:0] s2_tdata,
   input  logic [switch_pkg::axis_strb_width-1:0] s2_tstrb,
   input  logic [switch_pkg::user_width-1:0]      s2_tuser,
   input  logic                                   s2_tvalid,
   output logic                                   s2_tready,
   input  logic                                   s2_tlast,

   // CPU1
   input  logic [switch_pkg::axis_data_width-1:0] s3_tdata,
   input  logic [switch_pkg::axis_strb_width-1:0] s3_tstrb,
   input  logic [switch_pkg::user_width-1:0]      s3_tuser,
   input  logic                                   s3_tvalid,
   output logic                                   s3_tready,
   input  logic                                   s3_tlast,

   // Output stream
   output logic [switch_pkg::axis_data_width-1:0] m_tdata,
   output logic [switch_pkg::axis_strb_width-1:0] m_tstrb,
   output logic [switch_pkg::user_width-1:0]      m_tuser,
   output logic                                   m_tvalid,
   input  logic                                   m_tready,
   output logic                                   m_tlast
);

   axis_if s_if [0:3] ();
   axis_if arb_to_opl ();
   axis_if opl_out ();

   //////////////////////////////
   // Receive streams
   //////////////////////////////
   assign s_if[0].tdata  = s0_tdata;
   assign s_if[0].tstrb  = s0_tstrb;
   assign s_if[0].tuser  = s0_tuser;
   assign s_if[0].tvalid = s0_tvalid;
   assign s_if[0].tlast  = s0_tlast;
   assign s0_tready      = s_if[0].tready;

   assign s_if[1].tdata  = s1_tdata;
   assign s_if[1].tstrb  = s1_tstrb;
   assign s_if[1].tuser  = s1_tuser;
   assign s_if[1].tvalid = s1_tvalid;
   assign s_if[1].tlast  = s1_tlast;
   assign s1_tready      = s_if[1].tready;

   assign s_if[2].tdata  = s2_tdata;
   assign s_if[2].tstrb  = s2_tstrb;
   assign s_if[2].tuser  = s2_tuser;
   assign s_if[2].tvalid = s2_tvalid;
   assign s_if[2].tlast  = s2_tlast;
   assign s2_tready      = s_if[2].tready;

   assign s_if[3].tdata  = s3_tdata;
   assign s_if[3].tstrb  = s3_tstrb;
   assign s_if[3].tuser  = s3_tuser;
   assign s_if[3].tvalid = s3_tvalid;
   assign s_if[3].tlast  = s3_tlast;
   assign s3_tready      = s_if[3].tready;

   //////////////////////////////
   // Datapath chain
   //////////////////////////////
   input_arbiter u_input_arbiter (
      .clk        (clk),
      .axi_resetn (axi_resetn),
      .s          (s_if),
      .m          (arb_to_opl)
   );

   output_port_lookup u_output_port_lookup (
      .clk        (clk),
      .axi_resetn (axi_resetn),
      .s          (arb_to_opl),
      .m          (opl_out)
   );

   // Output stream
   assign m_tdata        = opl_out.tdata;
   assign m_tstrb        = opl_out.tstrb;
   assign m_tuser        = opl_out.tuser;
   assign m_tvalid       = opl_out.tvalid;
   assign m_tlast        = opl_out.tlast;
   assign opl_out.tready = m_tready;

endmodule

`default_nettype wire

// ==== test/tb_datapath.sv ====
/*
 * Switch datapath testbench
 * Drives the four receive streams, keeps expected beats per
 * source and checks port mapping, packet order and back-pressure
 */
`timescale 1ns/1ps
`default_nettype none

module tb_datapath;
   import switch_pkg::*;

   localparam int clk_period = 100;
   // About ten times the longest traffic mix below
   localparam int watchdog_cycles = 4000;

   logic                       clk;
   logic                       axi_resetn;
   logic [axis_data_width-1:0] s_tdata [num_ports];
   logic [axis_strb_width-1:0] s_tstrb [num_ports];
   logic [user_width-1:0]      s_tuser [num_ports];
   logic [num_ports-1:0]       s_tvalid;
   logic [num_ports-1:0]       s_tready;
   logic [num_ports-1:0]       s_tlast;
   logic [axis_data_width-1:0] m_tdata;
   logic [axis_strb_width-1:0] m_tstrb;
   logic [user_width-1:0]      m_tuser;
   logic                       m_tvalid;
   logic                       m_tready;
   logic                       m_tlast;

   integer       seed;
   // Expected beats per input with source and destination applied
   axis_beat_t   exp_q [num_ports][$];
   axis_beat_t   exp_beat;
   port_onehot_t mon_src;
   int           mon_idx;
   logic         src_ok;
   logic         exp_avail;
   logic         pkt_open;
   int           pkt_src;
   logic         reset_q;
   logic         bursts_done;
   int           pkt_count [num_ports];
   int           stall_count;
   // Source index of every packet start seen on m
   int           order_q [$];

   datapath_top u_dut (
      .clk        (clk),
      .axi_resetn (axi_resetn),
      .s0_tdata   (s_tdata[0]),
      .s0_tstrb   (s_tstrb[0]),
      .s0_tuser   (s_tuser[0]),
      .s0_tvalid  (s_tvalid[0]),
      .s0_tready  (s_tready[0]),
      .s0_tlast   (s_tlast[0]),
      .s1_tdata   (s_tdata[1]),
      .s1_tstrb   (s_tstrb[1]),
      .s1_tuser   (s_tuser[1]),
      .s1_tvalid  (s_tvalid[1]),
      .s1_tready  (s_tready[1]),
      .s1_tlast   (s_tlast[1]),
      .s2_tdata   (s_tdata[2]),
      .s2_tstrb   (s_tstrb[2]),
      .s2_tuser   (s_tuser[2]),
      .s2_tvalid  (s_tvalid[2]),
      .s2_tready  (s_tready[2]),
      .s2_tlast   (s_tlast[2]),
      .s3_tdata   (s_tdata[3]),
      .s3_tstrb   (s_tstrb[3]),
      .s3_tuser   (s_tuser[3]),
      .s3_tvalid  (s_tvalid[3]),
      .s3_tready  (s_tready[3]),
      .s3_tlast   (s_tlast[3]),
      .m_tdata    (m_tdata),
      .m_tstrb    (m_tstrb),
      .m_tuser    (m_tuser),
      .m_tvalid   (m_tvalid),
      .m_tready   (m_tready),
      .m_tlast    (m_tlast)
   );

   always #(clk_period / 2) clk = ~clk;

   //////////////////////////////
   // Port tables
   //////////////////////////////
   // MAC0, CPU0, MAC1, CPU1 on bits 0 to 3
   function automatic port_onehot_t source_code(input int k);
      case (k)
         0:       return 8'h01;
         1:       return 8'h02;
         2:       return 8'h04;
         default: return 8'h08;
      endcase
   endfunction

   // Each MAC pairs with its CPU port and back
   function automatic port_onehot_t paired_dst(input int k);
      case (k)
         0:       return 8'h02;
         1:       return 8'h01;
         2:       return 8'h08;
         default: return 8'h04;
      endcase
   endfunction

   //////////////////////////////
   // Failure reporting
   //////////////////////////////
   task automatic fail_and_stop();
      $display("*** TEST FAILED ***");
      $fatal(1, "stopped at first error");
   endtask

   task automatic abort_run(input string why);
      $display("%s", why);
      fail_and_stop();
   endtask

   task automatic report_mismatch(input string name, input logic [127:0] expected,
                                  input logic [127:0] actual);
      $display("ERR %s expected 0x%0h got 0x%0h", name, expected, actual);
      fail_and_stop();
   endtask

   //////////////////////////////
   // Monitor on m
   //////////////////////////////
   // Expected head for the source now on m
   always @(negedge clk) begin
      mon_src = m_tuser[src_port_pos +: 8];
      src_ok  = 1'b0;
      mon_idx = 0;
      for (int k = 0; k < num_ports; k++) begin
         if (mon_src == source_code(k)) begin
            src_ok  = 1'b1;
            mon_idx = k;
         end
      end
      exp_avail = src_ok && (exp_q[mon_idx].size() != 0);
      if (exp_avail) begin
         exp_beat = exp_q[mon_idx][0];
      end
      if (!axi_resetn && s_tready != '1) begin
         stall_count++;
      end
   end

   always @(posedge clk) begin
      reset_q <= axi_resetn;
      if (axi_resetn) begin
         pkt_open <= 1'b0;
      end else if (m_tvalid && m_tready) begin
         if (exp_avail) begin
            void'(exp_q[mon_idx].pop_front());
         end
         if (!pkt_open) begin
            order_q.push_back(mon_idx);
         end
         pkt_open <= !m_tlast;
         pkt_src  <= mon_idx;
      end
   end

   // Output quiet in reset and the first cycle after
   a_reset_quiet: assert property (@(posedge clk) (axi_resetn || reset_q) |-> !m_tvalid)
      else report_mismatch("m_tvalid", 128'(0), 128'($sampled(m_tvalid)));

   a_source_code: assert property (@(posedge clk) disable iff (axi_resetn)
      m_tvalid |-> src_ok)
      else abort_run("Output beat carries no valid source port code");

   // Nothing arrives unsent or twice
   a_was_sent: assert property (@(posedge clk) disable iff (axi_resetn)
      m_tvalid |-> exp_avail)
      else abort_run("Output beat has no matching beat left on its input");

   // No interleaving inside a packet
   a_packet_whole: assert property (@(posedge clk) disable iff (axi_resetn)
      (m_tvalid && pkt_open) |-> (mon_idx == pkt_src))
      else report_mismatch("m_tuser source index", 128'($sampled(pkt_src)),
                           128'($sampled(mon_idx)));

   a_data: assert property (@(posedge clk) disable iff (axi_resetn)
      (m_tvalid && exp_avail) |-> (m_tdata == exp_beat.data))
      else report_mismatch("m_tdata", 128'(exp_beat.data), 128'($sampled(m_tdata)));

   a_strb: assert property (@(posedge clk) disable iff (axi_resetn)
      (m_tvalid && exp_avail) |-> (m_tstrb == exp_beat.strb))
      else report_mismatch("m_tstrb", 128'(exp_beat.strb), 128'($sampled(m_tstrb)));

   // Source stamp, destination rewrite and length field
   a_user: assert property (@(posedge clk) disable iff (axi_resetn)
      (m_tvalid && exp_avail) |-> (m_tuser == exp_beat.user))
      else report_mismatch("m_tuser", exp_beat.user, $sampled(m_tuser));

   a_last: assert property (@(posedge clk) disable iff (axi_resetn)
      (m_tvalid && exp_avail) |-> (m_tlast == exp_beat.last))
      else report_mismatch("m_tlast", 128'(exp_beat.last), 128'($sampled(m_tlast)));

   initial begin
      #(watchdog_cycles * clk_period);
      abort_run($sformatf("Timeout after %0d clock cycles, traffic never drained",
                          watchdog_cycles));
   end

   //////////////////////////////
   // Stimulus tasks
   //////////////////////////////
   task automatic apply_reset();
      axi_resetn = 1'b1;
      repeat (8) @(negedge clk);
      axi_resetn = 1'b0;
      @(negedge clk);
      assert (s_tready == '1)
         else report_mismatch("s_tready", 128'hf, 128'(s_tready));
   endtask

   // One packet on input k with garbage in the source field
   task automatic send_packet(input int k, input int nbeats);
      axis_beat_t sent;
      axis_beat_t exp_b;
      for (int n = 0; n < nbeats; n++) begin
         @(negedge clk);
         sent.data = {8'(k), 8'(pkt_count[k]), 16'(n), 32'($random(seed))};
         sent.strb = (n == nbeats - 1) ? (8'($random(seed)) | 8'h01) : 8'hff;
         sent.user = {32'($random(seed)), 32'($random(seed)), 32'($random(seed)),
                      8'($random(seed)), 8'($random(seed)), 16'(nbeats * 8)};
         sent.last = (n == nbeats - 1);
         s_tdata[k]  = sent.data;
         s_tstrb[k]  = sent.strb;
         s_tuser[k]  = sent.user;
         s_tlast[k]  = sent.last;
         s_tvalid[k] = 1'b1;
         // tready is stable until the next rising edge
         while (!s_tready[k]) begin
            @(negedge clk);
         end
         exp_b = sent;
         exp_b.user[src_port_pos +: 8] = source_code(k);
         if (n == 0) begin
            exp_b.user[dst_port_pos +: 8] = paired_dst(k);
         end
         exp_q[k].push_back(exp_b);
      end
      @(negedge clk);
      s_tvalid[k] = 1'b0;
      s_tlast[k]  = 1'b0;
      pkt_count[k]++;
   endtask

   task automatic send_burst(input int k, input int npkts);
      int nbeats;
      for (int p = 0; p < npkts; p++) begin
         nbeats = 1 + int'($unsigned($random(seed)) % 6);
         send_packet(k, nbeats);
      end
   endtask

   task automatic wait_drain();
      while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() + exp_q[3].size() != 0) begin
         @(negedge clk);
      end
      repeat (2) @(negedge clk);
   endtask

   task automatic run_backpressure();
      int stall_base;
      stall_base  = stall_count;
      bursts_done = 1'b0;
      fork
         begin
            fork
               send_burst(0, 6);
               send_burst(1, 6);
               send_burst(2, 6);
               send_burst(3, 6);
            join
            bursts_done = 1'b1;
         end
         // Random sink ready two cycles in three
         while (!bursts_done) begin
            @(negedge clk);
            m_tready = ($random(seed) % 3) != 0;
         end
      join
      m_tready = 1'b1;
      wait_drain();
      assert (stall_count > stall_base)
         else abort_run("No receive stream dropped tready under back-pressure");
   endtask

   // Two packets per queue loaded behind a stalled sink before release
   task automatic check_round_robin();
      int base;
      m_tready = 1'b0;
      apply_reset();
      base = order_q.size();
      fork
         begin
            send_packet(0, 2);
            send_packet(0, 2);
         end
         begin
            send_packet(1, 2);
            send_packet(1, 2);
         end
         begin
            send_packet(2, 2);
            send_packet(2, 2);
         end
         begin
            send_packet(3, 2);
            send_packet(3, 2);
         end
      join
      repeat (2) @(negedge clk);
      m_tready = 1'b1;
      wait_drain();
      assert (order_q.size() == base + 2 * num_ports)
         else report_mismatch("packet count", 128'(base + 2 * num_ports),
                              128'(order_q.size()));
      for (int i = 0; i < 2 * num_ports; i++) begin
         assert (order_q[base + i] == i % num_ports)
            else report_mismatch("grant order index", 128'(i % num_ports),
                                 128'(order_q[base + i]));
      end
   endtask

   //////////////////////////////
   // Test sequence
   //////////////////////////////
   initial begin
      seed        = 92;
      clk         = 1'b0;
      axi_resetn  = 1'b1;
      m_tready    = 1'b1;
      s_tvalid    = '0;
      s_tlast     = '0;
      bursts_done = 1'b0;
      stall_count = 0;
      for (int k = 0; k < num_ports; k++) begin
         s_tdata[k]   = '0;
         s_tstrb[k]   = '0;
         s_tuser[k]   = '0;
         pkt_count[k] = 0;
      end
      apply_reset();

      // MAC ports up to their CPU ports
      send_packet(0, 3);
      wait_drain();
      send_packet(2, 4);
      wait_drain();
      // CPU ports down to their MAC ports
      send_packet(1, 2);
      wait_drain();
      send_packet(3, 5);
      wait_drain();

      // All inputs at once with the sink always ready
      fork
         send_burst(0, 4);
         send_burst(1, 4);
         send_burst(2, 4);
         send_burst(3, 4);
      join
      wait_drain();

      run_backpressure();
      check_round_robin();

      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

// ==== build.f ====
common/switch_pkg.sv
common/axis_if.sv
verilog/small_fifo.sv
input_arbiter/input_arbiter.sv
output_port_lookup/output_port_lookup.sv
verilog/datapath_top.sv
test/tb_datapath.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the switch datapath testbench with Verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert \
   --top-module tb_datapath \
   --Mdir obj_dir \
   -f build.f
status=$?
if [ "$status" -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/Vtb_datapath > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -Fq '*** TEST PASSED ***' "$log_file"; then
   exit 0
fi
echo "Pass message not found in $log_file"
exit 1
